// ==== include/raster_defs.svh ====
`ifndef RASTER_DEFS_SVH
`define RASTER_DEFS_SVH

// screen coordinates are unsigned.
`define RASTER_COORD_W 16

// edge values and coefficients are signed.
`define RASTER_EDGE_W 32

`endif

// ==== logic/geom_pkg.sv ====
package geom_pkg;

`include "raster_defs.svh"

    parameter int COORD_W = `RASTER_COORD_W;
    parameter int EDGE_W  = `RASTER_EDGE_W;

    // evaluates a*x + b*y + c at one pixel.
    function automatic logic signed [EDGE_W-1:0] edge_at(
        input logic signed [EDGE_W-1:0] a,
        input logic signed [EDGE_W-1:0] b,
        input logic signed [EDGE_W-1:0] c,
        input logic [COORD_W-1:0]       x,
        input logic [COORD_W-1:0]       y
    );
        logic signed [EDGE_W-1:0] xs;
        logic signed [EDGE_W-1:0] ys;
        xs = {{(EDGE_W-COORD_W){1'b0}}, x};
        ys = {{(EDGE_W-COORD_W){1'b0}}, y};
        return a * xs + b * ys + c;
    endfunction

endpackage

// ==== logic/pixel_pkg.sv ====
package pixel_pkg;

`include "raster_defs.svh"

    // pixel coordinates share the geometry width.
    parameter int PIX_W   = `RASTER_COORD_W;
    parameter int COLOR_W = 12;

    parameter int DEF_WIDTH  = 320;
    parameter int DEF_HEIGHT = 240;
    parameter int DEF_LANES  = 4;

endpackage

// ==== logic/triangle_setup.sv ====
`default_nettype none
`timescale 1ns/10ps

module triangle_setup
    import geom_pkg::*;
    import pixel_pkg::*;
#(
    parameter int WIDTH  = 320,
    parameter int HEIGHT = 240
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [COORD_W-1:0]         v0_x, v0_y,
    input  wire logic [COORD_W-1:0]         v1_x, v1_y,
    input  wire logic [COORD_W-1:0]         v2_x, v2_y,
    input  wire logic [COLOR_W-1:0]         color,
    input  wire logic                       in_valid,
    input  wire logic                       tri_ready,
    output logic                            in_ready,
    output logic                            tri_valid,
    output logic                            reject,
    output logic signed [EDGE_W-1:0]        a0, b0, c0,
    output logic signed [EDGE_W-1:0]        a1, b1, c1,
    output logic signed [EDGE_W-1:0]        a2, b2, c2,
    output logic [COORD_W-1:0]              box_x0, box_y0, box_x1, box_y1,
    output logic [COLOR_W-1:0]              tri_color
);

    localparam logic [COORD_W-1:0] MAX_X = COORD_W'(WIDTH - 1);
    localparam logic [COORD_W-1:0] MAX_Y = COORD_W'(HEIGHT - 1);

    logic signed [EDGE_W-1:0] xs0, ys0, xs1, ys1, xs2, ys2;
    logic signed [EDGE_W-1:0] na0, nb0, nc0;
    logic signed [EDGE_W-1:0] na1, nb1, nc1;
    logic signed [EDGE_W-1:0] na2, nb2, nc2;
    logic signed [EDGE_W-1:0] area;
    logic [COORD_W-1:0]       lo_x, lo_y, hi_x, hi_y;
    logic                     accept;
    logic                     ccw;

    assign xs0 = {{(EDGE_W-COORD_W){1'b0}}, v0_x};
    assign ys0 = {{(EDGE_W-COORD_W){1'b0}}, v0_y};
    assign xs1 = {{(EDGE_W-COORD_W){1'b0}}, v1_x};
    assign ys1 = {{(EDGE_W-COORD_W){1'b0}}, v1_y};
    assign xs2 = {{(EDGE_W-COORD_W){1'b0}}, v2_x};
    assign ys2 = {{(EDGE_W-COORD_W){1'b0}}, v2_y};

    // edge i runs from vertex i to vertex i+1 and is non-negative inside.
    assign na0 = ys1 - ys0;
    assign nb0 = xs0 - xs1;
    assign nc0 = xs1 * ys0 - xs0 * ys1;
    assign na1 = ys2 - ys1;
    assign nb1 = xs1 - xs2;
    assign nc1 = xs2 * ys1 - xs1 * ys2;
    assign na2 = ys0 - ys2;
    assign nb2 = xs2 - xs0;
    assign nc2 = xs0 * ys2 - xs2 * ys0;

    // edge 0 seen from the opposite vertex is twice the signed area.
    assign area   = edge_at(na0, nb0, nc0, v2_x, v2_y);
    assign ccw    = area > 0;
    assign accept = in_valid && in_ready;

    always_comb begin
        lo_x = v0_x;
        hi_x = v0_x;
        lo_y = v0_y;
        hi_y = v0_y;
        if (v1_x < lo_x) lo_x = v1_x;
        if (v2_x < lo_x) lo_x = v2_x;
        if (v1_x > hi_x) hi_x = v1_x;
        if (v2_x > hi_x) hi_x = v2_x;
        if (v1_y < lo_y) lo_y = v1_y;
        if (v2_y < lo_y) lo_y = v2_y;
        if (v1_y > hi_y) hi_y = v1_y;
        if (v2_y > hi_y) hi_y = v2_y;
        // clip both corners so a box past the screen edge stays ordered.
        if (lo_x > MAX_X) lo_x = MAX_X;
        if (hi_x > MAX_X) hi_x = MAX_X;
        if (lo_y > MAX_Y) lo_y = MAX_Y;
        if (hi_y > MAX_Y) hi_y = MAX_Y;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ready  <= 1'b0;
            tri_valid <= 1'b0;
            reject    <= 1'b0;
        end else begin
            in_ready <= !accept && !(tri_valid && !tri_ready);
            reject   <= accept && !ccw;
            if (accept) begin
                tri_valid <= ccw;
            end else if (tri_ready) begin
                tri_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            a0        <= na0;
            b0        <= nb0;
            c0        <= nc0;
            a1        <= na1;
            b1        <= nb1;
            c1        <= nc1;
            a2        <= na2;
            b2        <= nb2;
            c2        <= nc2;
            box_x0    <= lo_x;
            box_y0    <= lo_y;
            box_x1    <= hi_x;
            box_y1    <= hi_y;
            tri_color <= color;
        end
    end

endmodule

// ==== logic/span_walker.sv ====
`default_nettype none
`timescale 1ns/10ps

module span_walker
    import geom_pkg::*;
    import pixel_pkg::*;
#(
    parameter int LANES = 4
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       tri_valid,
    input  wire logic signed [EDGE_W-1:0]   a0, b0, c0,
    input  wire logic signed [EDGE_W-1:0]   a1, b1, c1,
    input  wire logic signed [EDGE_W-1:0]   a2, b2, c2,
    input  wire logic [COORD_W-1:0]         box_x0, box_y0, box_x1, box_y1,
    input  wire logic [COLOR_W-1:0]         tri_color,
    input  wire logic                       span_ready,
    output logic                            tri_ready,
    output logic                            span_valid,
    output logic [COORD_W-1:0]              span_x, span_y,
    output logic signed [EDGE_W-1:0]        e0, e1, e2,
    output logic signed [EDGE_W-1:0]        ea0, ea1, ea2,
    output logic [COORD_W-1:0]              span_x1,
    output logic [COLOR_W-1:0]              span_color,
    output logic                            last_span
);

    logic signed [EDGE_W-1:0] lanes_s;
    logic signed [EDGE_W-1:0] s0, s1, s2;
    logic signed [EDGE_W-1:0] r0_q, r1_q, r2_q;
    logic signed [EDGE_W-1:0] b0_q, b1_q, b2_q;
    logic [COORD_W-1:0]       row_x0_q;
    logic [COORD_W-1:0]       last_y_q;
    logic                     start;
    logic                     take;
    logic                     row_end;

    assign lanes_s = EDGE_W'(LANES);

    // edge values at the top left corner of the box.
    assign s0 = edge_at(a0, b0, c0, box_x0, box_y0);
    assign s1 = edge_at(a1, b1, c1, box_x0, box_y0);
    assign s2 = edge_at(a2, b2, c2, box_x0, box_y0);

    assign tri_ready = !span_valid;
    assign start     = tri_valid && tri_ready;
    assign take      = span_valid && span_ready;

    // the span reaches the right box edge.
    assign row_end   = ({1'b0, span_x} + (COORD_W+1)'(LANES)) > {1'b0, span_x1};
    assign last_span = span_valid && row_end && (span_y == last_y_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            span_valid <= 1'b0;
        end else if (start) begin
            span_valid <= 1'b1;
        end else if (take && last_span) begin
            span_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            ea0        <= a0;
            ea1        <= a1;
            ea2        <= a2;
            b0_q       <= b0;
            b1_q       <= b1;
            b2_q       <= b2;
            r0_q       <= s0;
            r1_q       <= s1;
            r2_q       <= s2;
            e0         <= s0;
            e1         <= s1;
            e2         <= s2;
            row_x0_q   <= box_x0;
            last_y_q   <= box_y1;
            span_x1    <= box_x1;
            span_x     <= box_x0;
            span_y     <= box_y0;
            span_color <= tri_color;
        end else if (take) begin
            if (row_end) begin
                // next row restarts at the left box edge.
                span_x <= row_x0_q;
                span_y <= span_y + 1'b1;
                r0_q   <= r0_q + b0_q;
                r1_q   <= r1_q + b1_q;
                r2_q   <= r2_q + b2_q;
                e0     <= r0_q + b0_q;
                e1     <= r1_q + b1_q;
                e2     <= r2_q + b2_q;
            end else begin
                span_x <= span_x + COORD_W'(LANES);
                e0     <= e0 + ea0 * lanes_s;
                e1     <= e1 + ea1 * lanes_s;
                e2     <= e2 + ea2 * lanes_s;
            end
        end
    end

endmodule

// ==== logic/edge_lane.sv ====
`default_nettype none
`timescale 1ns/10ps

module edge_lane
    import geom_pkg::*;
#(
    parameter int LANE_INDEX = 0
) (
    input  wire logic [COORD_W-1:0]         span_x,
    input  wire logic signed [EDGE_W-1:0]   e0, e1, e2,
    input  wire logic signed [EDGE_W-1:0]   ea0, ea1, ea2,
    input  wire logic [COORD_W-1:0]         span_x1,
    output logic                            covered
);

    logic signed [EDGE_W-1:0] offset;
    logic signed [EDGE_W-1:0] f0, f1, f2;
    logic                     in_box;

    assign offset = EDGE_W'(LANE_INDEX);

    // step each edge from the span start to this lane.
    assign f0 = e0 + ea0 * offset;
    assign f1 = e1 + ea1 * offset;
    assign f2 = e2 + ea2 * offset;

    // lanes past the right box edge belong to no pixel.
    assign in_box = ({1'b0, span_x} + (COORD_W+1)'(LANE_INDEX)) <= {1'b0, span_x1};

    assign covered = in_box && !f0[EDGE_W-1] && !f1[EDGE_W-1] && !f2[EDGE_W-1];

endmodule

// ==== logic/span_drain.sv ====
`default_nettype none
`timescale 1ns/10ps

module span_drain
    import pixel_pkg::*;
#(
    parameter int LANES = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   span_valid,
    input  wire logic [LANES-1:0]       cover_mask,
    input  wire logic [PIX_W-1:0]       span_x, span_y,
    input  wire logic [COLOR_W-1:0]     span_color,
    input  wire logic                   last_span,
    input  wire logic                   reject,
    input  wire logic                   out_ready,
    output logic                        span_ready,
    output logic                        out_valid,
    output logic [PIX_W-1:0]            pixel_x, pixel_y,
    output logic [COLOR_W-1:0]          pixel_color,
    output logic                        done
);

    localparam int IDX_W = (LANES > 1) ? $clog2(LANES) : 1;

    logic [LANES-1:0] mask_q;
    logic [LANES-1:0] low;
    logic [LANES-1:0] rest;
    logic [IDX_W-1:0] idx;
    logic [PIX_W-1:0] x_q;
    logic             last_q;
    logic             load;
    logic             fire;

    assign span_ready = (mask_q == '0);
    assign out_valid  = !span_ready;
    assign load       = span_valid && span_ready;
    assign fire       = out_valid && out_ready;

    // lowest lane goes first.
    assign low  = mask_q & (~mask_q + 1'b1);
    assign rest = mask_q & ~low;

    always_comb begin
        idx = '0;
        for (int i = 0; i < LANES; i++) begin
            if (low[i]) begin
                idx = IDX_W'(i);
            end
        end
    end

    assign pixel_x = x_q + PIX_W'(idx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask_q <= '0;
            last_q <= 1'b0;
            done   <= 1'b0;
        end else begin
            // an empty final span ends the triangle as soon as it is taken.
            done <= reject
                 || (load && last_span && cover_mask == '0)
                 || (fire && last_q && rest == '0);
            if (load) begin
                mask_q <= cover_mask;
                last_q <= last_span;
            end else if (fire) begin
                mask_q <= rest;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            x_q         <= span_x;
            pixel_y     <= span_y;
            pixel_color <= span_color;
        end
    end

endmodule

// ==== logic/rasterizer.sv ====
`default_nettype none
`timescale 1ns/10ps

module rasterizer
    import geom_pkg::*;
    import pixel_pkg::*;
#(
    parameter int WIDTH  = DEF_WIDTH,
    parameter int HEIGHT = DEF_HEIGHT,
    parameter int LANES  = DEF_LANES
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [COORD_W-1:0]     v0_x, v0_y,
    input  wire logic [COORD_W-1:0]     v1_x, v1_y,
    input  wire logic [COORD_W-1:0]     v2_x, v2_y,
    input  wire logic [COLOR_W-1:0]     color,
    input  wire logic                   in_valid,
    input  wire logic                   out_ready,
    output logic                        in_ready,
    output logic [PIX_W-1:0]            pixel_x, pixel_y,
    output logic [COLOR_W-1:0]          pixel_color,
    output logic                        out_valid,
    output logic                        done
);

    // setup to walker.
    logic                     tri_valid;
    logic                     tri_ready;
    logic                     reject;
    logic signed [EDGE_W-1:0] a0, b0, c0;
    logic signed [EDGE_W-1:0] a1, b1, c1;
    logic signed [EDGE_W-1:0] a2, b2, c2;
    logic [COORD_W-1:0]       box_x0, box_y0, box_x1, box_y1;
    logic [COLOR_W-1:0]       tri_color;

    // walker to lanes and drain.
    logic                     span_valid;
    logic                     span_ready;
    logic [COORD_W-1:0]       span_x, span_y, span_x1;
    logic signed [EDGE_W-1:0] e0, e1, e2;
    logic signed [EDGE_W-1:0] ea0, ea1, ea2;
    logic [COLOR_W-1:0]       span_color;
    logic                     last_span;
    logic [LANES-1:0]         cover_mask;

    triangle_setup #(
        .WIDTH(WIDTH),
        .HEIGHT(HEIGHT)
    ) u_setup (
        .clk(clk),
        .rst_n(rst_n),
        .v0_x(v0_x), .v0_y(v0_y),
        .v1_x(v1_x), .v1_y(v1_y),
        .v2_x(v2_x), .v2_y(v2_y),
        .color(color),
        .in_valid(in_valid),
        .tri_ready(tri_ready),
        .in_ready(in_ready),
        .tri_valid(tri_valid),
        .reject(reject),
        .a0(a0), .b0(b0), .c0(c0),
        .a1(a1), .b1(b1), .c1(c1),
        .a2(a2), .b2(b2), .c2(c2),
        .box_x0(box_x0), .box_y0(box_y0),
        .box_x1(box_x1), .box_y1(box_y1),
        .tri_color(tri_color)
    );

    span_walker #(
        .LANES(LANES)
    ) u_walker (
        .clk(clk),
        .rst_n(rst_n),
        .tri_valid(tri_valid),
        .a0(a0), .b0(b0), .c0(c0),
        .a1(a1), .b1(b1), .c1(c1),
        .a2(a2), .b2(b2), .c2(c2),
        .box_x0(box_x0), .box_y0(box_y0),
        .box_x1(box_x1), .box_y1(box_y1),
        .tri_color(tri_color),
        .span_ready(span_ready),
        .tri_ready(tri_ready),
        .span_valid(span_valid),
        .span_x(span_x), .span_y(span_y),
        .e0(e0), .e1(e1), .e2(e2),
        .ea0(ea0), .ea1(ea1), .ea2(ea2),
        .span_x1(span_x1),
        .span_color(span_color),
        .last_span(last_span)
    );

    // one lane per pixel of the span.
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        edge_lane #(
            .LANE_INDEX(i)
        ) u_lane (
            .span_x(span_x),
            .e0(e0), .e1(e1), .e2(e2),
            .ea0(ea0), .ea1(ea1), .ea2(ea2),
            .span_x1(span_x1),
            .covered(cover_mask[i])
        );
    end

    span_drain #(
        .LANES(LANES)
    ) u_drain (
        .clk(clk),
        .rst_n(rst_n),
        .span_valid(span_valid),
        .cover_mask(cover_mask),
        .span_x(span_x), .span_y(span_y),
        .span_color(span_color),
        .last_span(last_span),
        .reject(reject),
        .out_ready(out_ready),
        .span_ready(span_ready),
        .out_valid(out_valid),
        .pixel_x(pixel_x), .pixel_y(pixel_y),
        .pixel_color(pixel_color),
        .done(done)
    );

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release on a falling edge away from the sampling edge.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== sim/rasterizer_sva.sv ====
`timescale 1ns/10ps

module rasterizer_sva
    import pixel_pkg::*;
#(
    parameter int WIDTH  = DEF_WIDTH,
    parameter int HEIGHT = DEF_HEIGHT
) (
    input wire logic               clk,
    input wire logic               rst_n,
    input wire logic               in_ready,
    input wire logic               out_valid,
    input wire logic               out_ready,
    input wire logic [PIX_W-1:0]   pixel_x,
    input wire logic [PIX_W-1:0]   pixel_y,
    input wire logic [COLOR_W-1:0] pixel_color
);

    int unsigned fail_count = 0;

    // a stalled pixel stays put until it is taken.
    hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(pixel_x)
            && $stable(pixel_y) && $stable(pixel_color))
    else begin
        fail_count = fail_count + 1;
        $error("pixel changed while out_ready was low");
    end

    on_screen: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> pixel_x < WIDTH && pixel_y < HEIGHT)
    else begin
        fail_count = fail_count + 1;
        $error("pixel outside the screen");
    end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !in_ready && !out_valid)
    else begin
        fail_count = fail_count + 1;
        $error("handshake active during reset");
    end

endmodule

bind rasterizer rasterizer_sva #(
    .WIDTH(WIDTH),
    .HEIGHT(HEIGHT)
) u_sva (
    .clk(clk),
    .rst_n(rst_n),
    .in_ready(in_ready),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .pixel_x(pixel_x),
    .pixel_y(pixel_y),
    .pixel_color(pixel_color)
);

// ==== sim/rasterizer_tb.sv ====
`timescale 1ns/10ps

module rasterizer_tb
    import geom_pkg::*;
    import pixel_pkg::*;
();

    localparam int WIDTH  = DEF_WIDTH;
    localparam int HEIGHT = DEF_HEIGHT;
    localparam int LANES  = DEF_LANES;

    // 200 triangles of at most a 24 x 24 box plus slack and doubled for stalls.
    localparam int CYCLE_LIMIT = 200 * (576 + 50) * 2;

    logic               clk;
    logic               rst_n;
    logic [COORD_W-1:0] v0_x, v0_y, v1_x, v1_y, v2_x, v2_y;
    logic [COLOR_W-1:0] color;
    logic               in_valid;
    logic               out_ready;
    logic               in_ready;
    logic [PIX_W-1:0]   pixel_x, pixel_y;
    logic [COLOR_W-1:0] pixel_color;
    logic               out_valid;
    logic               done;

    int          tx[0:255][0:2];
    int          ty[0:255][0:2];
    int          tcol[0:255];
    int          cnt_model[0:255];
    int          got_pix[0:255];
    int          tri_n;
    int          exp_x[$];
    int          exp_y[$];
    int          exp_c[$];
    int          exp_tag[$];
    int unsigned rng_state = 88;
    string       cur_test;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          pixels_seen;
    int          cycles;

    tb_clock clock_gen (
        .clk(clk),
        .rst_n(rst_n)
    );

    rasterizer #(
        .WIDTH(WIDTH),
        .HEIGHT(HEIGHT),
        .LANES(LANES)
    ) UUT (
        .clk(clk), .rst_n(rst_n),
        .v0_x(v0_x), .v0_y(v0_y), .v1_x(v1_x), .v1_y(v1_y), .v2_x(v2_x), .v2_y(v2_y),
        .color(color), .in_valid(in_valid), .out_ready(out_ready), .in_ready(in_ready),
        .pixel_x(pixel_x), .pixel_y(pixel_y), .pixel_color(pixel_color),
        .out_valid(out_valid), .done(done)
    );

    function automatic int rand_below(input int n);
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return int'((rng_state >> 8) % n);
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            errors++;
            $display("FAILED %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR %s: %s", cur_test, msg);
    endtask

    // twice the signed area is edge 0 seen from vertex 2.
    function automatic int tri_area(input int i);
        return edge_at(ty[i][1] - ty[i][0], tx[i][0] - tx[i][1],
                       tx[i][1] * ty[i][0] - tx[i][0] * ty[i][1],
                       COORD_W'(tx[i][2]), COORD_W'(ty[i][2]));
    endfunction

    // brute-force scan of the clipped box in row-major order.
    task automatic add_expected(input int i);
        logic signed [EDGE_W-1:0] a[3];
        logic signed [EDGE_W-1:0] b[3];
        logic signed [EDGE_W-1:0] c[3];
        int j;
        int lo_x, hi_x, lo_y, hi_y;
        cnt_model[i] = 0;
        got_pix[i] = 0;
        if (tri_area(i) <= 0) begin
            return;
        end
        lo_x = tx[i][0];
        hi_x = tx[i][0];
        lo_y = ty[i][0];
        hi_y = ty[i][0];
        for (int k = 0; k < 3; k++) begin
            j = (k + 1) % 3;
            a[k] = ty[i][j] - ty[i][k];
            b[k] = tx[i][k] - tx[i][j];
            c[k] = tx[i][j] * ty[i][k] - tx[i][k] * ty[i][j];
            if (tx[i][k] < lo_x) lo_x = tx[i][k];
            if (tx[i][k] > hi_x) hi_x = tx[i][k];
            if (ty[i][k] < lo_y) lo_y = ty[i][k];
            if (ty[i][k] > hi_y) hi_y = ty[i][k];
        end
        if (lo_x > WIDTH - 1) lo_x = WIDTH - 1;
        if (hi_x > WIDTH - 1) hi_x = WIDTH - 1;
        if (lo_y > HEIGHT - 1) lo_y = HEIGHT - 1;
        if (hi_y > HEIGHT - 1) hi_y = HEIGHT - 1;
        for (int y = lo_y; y <= hi_y; y++) begin
            for (int x = lo_x; x <= hi_x; x++) begin
                if (edge_at(a[0], b[0], c[0], COORD_W'(x), COORD_W'(y)) >= 0
                        && edge_at(a[1], b[1], c[1], COORD_W'(x), COORD_W'(y)) >= 0
                        && edge_at(a[2], b[2], c[2], COORD_W'(x), COORD_W'(y)) >= 0) begin
                    exp_x.push_back(x);
                    exp_y.push_back(y);
                    exp_c.push_back(tcol[i]);
                    exp_tag.push_back(i);
                    cnt_model[i]++;
                end
            end
        end
    endtask

    task automatic set_triangle(input int i, input int x0, input int y0, input int x1,
                                input int y1, input int x2, input int y2, input int col);
        tx[i][0] = x0;
        ty[i][0] = y0;
        tx[i][1] = x1;
        ty[i][1] = y1;
        tx[i][2] = x2;
        ty[i][2] = y2;
        tcol[i] = col;
    endtask

    task automatic make_triangle(input int i, input bit near_edge, input bit force_ccw);
        int ox;
        int oy;
        int t;
        do begin
            ox = rand_below(WIDTH - 24);
            oy = rand_below(HEIGHT - 24);
            // the window hangs over the right or the bottom screen edge.
            if (near_edge && rand_below(2) == 0) begin
                ox = WIDTH - 16 + rand_below(12);
            end else if (near_edge) begin
                oy = HEIGHT - 16 + rand_below(12);
            end
            for (int k = 0; k < 3; k++) begin
                tx[i][k] = ox + rand_below(24);
                ty[i][k] = oy + rand_below(24);
            end
        end while (force_ccw && tri_area(i) == 0);
        if (tri_area(i) < 0) begin
            t = tx[i][1];
            tx[i][1] = tx[i][2];
            tx[i][2] = t;
            t = ty[i][1];
            ty[i][1] = ty[i][2];
            ty[i][2] = t;
        end
        tcol[i] = rand_below(4096);
    endtask

    task automatic drive_triangle(input int i);
        v0_x = COORD_W'(tx[i][0]);
        v0_y = COORD_W'(ty[i][0]);
        v1_x = COORD_W'(tx[i][1]);
        v1_y = COORD_W'(ty[i][1]);
        v2_x = COORD_W'(tx[i][2]);
        v2_y = COORD_W'(ty[i][2]);
        color = COLOR_W'(tcol[i]);
    endtask

    // one pass per falling edge samples the outputs and then drives the next inputs.
    task automatic run_batch(input string name, input bit overlap, input int ready_mode);
        int sent;
        int finished;
        int stall;
        int idle;
        int t;
        int err_start;
        int pix_start;
        bit handed;
        cur_test = name;
        err_start = errors;
        pix_start = pixels_seen;
        exp_x.delete();
        exp_y.delete();
        exp_c.delete();
        exp_tag.delete();
        for (int i = 0; i < tri_n; i++) begin
            add_expected(i);
        end
        sent = 0;
        finished = 0;
        stall = 0;
        idle = 0;
        handed = 1'b0;
        while (idle < 6) begin
            @(negedge clk);
            if (done) begin
                if (finished >= sent) begin
                    report_error("done pulse with no triangle in flight");
                end else begin
                    check_value($sformatf("pixel count of triangle %0d", finished),
                                cnt_model[finished], got_pix[finished]);
                    finished++;
                end
            end
            case (ready_mode)
                0: out_ready = 1'b1;
                1: out_ready = (rand_below(4) != 0);
                default: begin
                    if (stall > 0) begin
                        stall--;
                    end else if (rand_below(8) == 0) begin
                        stall = 1 + rand_below(12);
                    end
                    out_ready = (stall == 0);
                end
            endcase
            if (out_valid && out_ready) begin
                pixels_seen++;
                if (exp_x.size() == 0) begin
                    report_error($sformatf("unexpected pixel at (%0d, %0d)", pixel_x, pixel_y));
                end else begin
                    t = exp_tag.pop_front();
                    check_value("pixel x", exp_x.pop_front(), int'(pixel_x));
                    check_value("pixel y", exp_y.pop_front(), int'(pixel_y));
                    check_value("pixel color", exp_c.pop_front(), int'(pixel_color));
                    got_pix[t]++;
                end
            end
            if (handed) begin
                in_valid = 1'b0;
                handed = 1'b0;
            end
            if (!in_valid && sent < tri_n && (overlap || finished == sent)) begin
                drive_triangle(sent);
                in_valid = 1'b1;
            end
            if (in_valid && in_ready) begin
                handed = 1'b1;
                sent++;
                // setup, walker and drain hold one triangle each.
                if (sent - finished > 3) begin
                    report_error("in_ready rose before the earlier spans were taken");
                end
            end
            if (finished == tri_n) begin
                idle++;
            end
        end
        if (exp_x.size() != 0) begin
            report_error($sformatf("%0d expected pixels never came out", exp_x.size()));
        end
        tests_run++;
        if (errors != err_start) begin
            tests_failed++;
        end
        $display("test %s: %0d triangles, %0d pixels, %0d errors",
                 name, tri_n, pixels_seen - pix_start, errors - err_start);
    endtask

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: run timed out after %0d cycles without finishing", cycles);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        in_valid = 1'b0;
        out_ready = 1'b0;
        v0_x = '0;
        v0_y = '0;
        v1_x = '0;
        v1_y = '0;
        v2_x = '0;
        v2_y = '0;
        color = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        pixels_seen = 0;
        cur_test = "reset";
        @(posedge rst_n);
        @(negedge clk);
        check_value("in_ready", 1, int'(in_ready));

        tri_n = 1;
        set_triangle(0, 40, 30, 30, 60, 70, 50, 'hA5C);
        run_batch("fixed", 1'b0, 0);

        tri_n = 3;
        set_triangle(0, 40, 30, 70, 50, 30, 60, 'h123);
        set_triangle(1, 10, 10, 20, 20, 30, 30, 'h456);
        set_triangle(2, 5, 5, 5, 5, 5, 5, 'h789);
        run_batch("reject", 1'b0, 0);

        tri_n = 200;
        for (int i = 0; i < tri_n; i++) begin
            make_triangle(i, rand_below(8) == 0, 1'b0);
        end
        run_batch("random", 1'b0, 1);

        tri_n = 20;
        for (int i = 0; i < tri_n; i++) begin
            make_triangle(i, 1'b1, 1'b0);
        end
        run_batch("clip", 1'b0, 1);

        // back to back triangles while the output stalls.
        tri_n = 30;
        for (int i = 0; i < tri_n; i++) begin
            make_triangle(i, rand_below(4) == 0, 1'b1);
        end
        run_batch("backpressure", 1'b1, 2);

        errors = errors + int'(UUT.u_sva.fail_count);
        $display("summary: %0d tests, %0d failed, %0d pixels, %0d assertion failures, %0d errors",
                 tests_run, tests_failed, pixels_seen, UUT.u_sva.fail_count, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
logic/geom_pkg.sv
logic/pixel_pkg.sv
logic/triangle_setup.sv
logic/span_walker.sv
logic/edge_lane.sv
logic/span_drain.sv
logic/rasterizer.sv
sim/tb_clock.sv
sim/rasterizer_sva.sv
sim/rasterizer_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rasterizer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rasterizer_tb \
    -f flist.f -o sim_rasterizer
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_rasterizer +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0
